// ==== gvp_params.svh ====
`ifndef GVP_PARAMS_SVH
`define GVP_PARAMS_SVH

////////////////////////////////////////////////////////////
// program memory geometry
////////////////////////////////////////////////////////////

// number of vector slots in the program table
`define GVP_NUM_VECTORS 16

// vector address width, log2 of the slot count
`define GVP_ADDR_W 4

////////////////////////////////////////////////////////////
// data path
////////////////////////////////////////////////////////////

// width of counts, options, decimation and positions
`define GVP_WORD_W 32

// store credits after reset, equal to the recorder buffer depth
`define GVP_STORE_CREDITS 4

`endif

// ==== gvp_pkg.sv ====
`default_nettype none

`include "gvp_params.svh"

package gvp_pkg;

    ////////////////////////////////////////////////////////////
    // vector field types
    ////////////////////////////////////////////////////////////

    // unsigned fields: counts, options, decimation
    typedef logic [`GVP_WORD_W-1:0] gvp_word_t;

    // signed increments and positions, two's complement wrap
    typedef logic signed [`GVP_WORD_W-1:0] gvp_coord_t;

    // program counter / vector slot
    typedef logic [`GVP_ADDR_W-1:0] gvp_addr_t;

    // relative jump, one bit wider than the address for the sign
    typedef logic signed [`GVP_ADDR_W:0] gvp_jump_t;

    ////////////////////////////////////////////////////////////
    // control encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic {
        STORE_POINT  = 1'b0, // data point sample
        STORE_HEADER = 1'b1  // full vector header
    } store_kind_t;

    typedef enum logic [1:0] {
        SEQ_IDLE, // waiting for run, idle options out
        SEQ_LOAD, // header store and counter load
        SEQ_STEP, // intermediate and point steps
        SEQ_DONE  // end vector reached
    } seq_state_t;

endpackage

`default_nettype wire

// ==== vector_program_ram.sv ====
`default_nettype none

`include "gvp_params.svh"

module vector_program_ram
    import gvp_pkg::*;
(
    input  wire logic       a_clk,
    input  wire logic       reset_flg,
    input  wire logic       setvec,      // host write strobe
    input  wire gvp_addr_t  vec_addr,
    input  wire gvp_word_t  set_n,
    input  wire gvp_word_t  set_nii,
    input  wire gvp_word_t  set_options,
    input  wire gvp_word_t  set_nrep,
    input  wire gvp_word_t  set_deci,
    input  wire gvp_jump_t  set_next,
    input  wire gvp_coord_t set_dx,
    input  wire gvp_coord_t set_dy,
    input  wire gvp_coord_t set_dz,
    input  wire gvp_coord_t set_du,
    input  wire logic       run,
    input  wire gvp_addr_t  pvc,         // current vector from sequencer
    input  wire logic       loop_dec,
    input  wire logic       loop_reload,
    output gvp_word_t       cur_n,
    output gvp_word_t       cur_nii,
    output gvp_word_t       cur_options,
    output gvp_word_t       cur_deci,
    output gvp_word_t       loop_cnt,
    output gvp_jump_t       cur_next,
    output gvp_coord_t      cur_dx,
    output gvp_coord_t      cur_dy,
    output gvp_coord_t      cur_dz,
    output gvp_coord_t      cur_du
);

    // vector table, one entry per field
    gvp_word_t  vec_n       [`GVP_NUM_VECTORS];
    gvp_word_t  vec_nii     [`GVP_NUM_VECTORS];
    gvp_word_t  vec_options [`GVP_NUM_VECTORS];
    gvp_word_t  vec_nrep    [`GVP_NUM_VECTORS];
    gvp_word_t  vec_deci    [`GVP_NUM_VECTORS];
    gvp_jump_t  vec_next    [`GVP_NUM_VECTORS];
    gvp_coord_t vec_dx      [`GVP_NUM_VECTORS];
    gvp_coord_t vec_dy      [`GVP_NUM_VECTORS];
    gvp_coord_t vec_dz      [`GVP_NUM_VECTORS];
    gvp_coord_t vec_du      [`GVP_NUM_VECTORS];
    gvp_word_t  loop_ctr    [`GVP_NUM_VECTORS]; // live repeat counters

    logic wr_en;

    assign wr_en = setvec && !run; // table frozen while running

    always_ff @(posedge a_clk)
    begin
        if (wr_en)
        begin
            vec_n[vec_addr]       <= set_n;
            vec_nii[vec_addr]     <= set_nii;
            vec_options[vec_addr] <= set_options;
            vec_nrep[vec_addr]    <= set_nrep;
            vec_deci[vec_addr]    <= set_deci;
            vec_next[vec_addr]    <= set_next;
            vec_dx[vec_addr]      <= set_dx;
            vec_dy[vec_addr]      <= set_dy;
            vec_dz[vec_addr]      <= set_dz;
            vec_du[vec_addr]      <= set_du;
        end
    end

    // loop counters: write arms, section end decrements or reloads
    always_ff @(posedge a_clk)
    begin
        if (reset_flg)
        begin
            for (int k = 0; k < `GVP_NUM_VECTORS; k++)
                loop_ctr[k] <= vec_nrep[k]; // back to programmed repeats
        end
        else if (wr_en)
            loop_ctr[vec_addr] <= set_nrep;
        else if (loop_dec)
            loop_ctr[pvc] <= loop_ctr[pvc] - 1'b1; // one more pass taken
        else if (loop_reload)
            loop_ctr[pvc] <= vec_nrep[pvc]; // ready for next entry into loop
    end

    // async read of the current vector
    assign cur_n       = vec_n[pvc];
    assign cur_nii     = vec_nii[pvc];
    assign cur_options = vec_options[pvc];
    assign cur_deci    = vec_deci[pvc];
    assign cur_next    = vec_next[pvc];
    assign cur_dx      = vec_dx[pvc];
    assign cur_dy      = vec_dy[pvc];
    assign cur_dz      = vec_dz[pvc];
    assign cur_du      = vec_du[pvc];
    assign loop_cnt    = loop_ctr[pvc];

    // host must not program while the sequencer walks the table
    a_setvec_idle: assert property (@(posedge a_clk) disable iff (reset_flg)
        setvec |-> !run);

endmodule

`default_nettype wire

// ==== step_sequencer.sv ====
`default_nettype none

`include "gvp_params.svh"

module step_sequencer
    import gvp_pkg::*;
(
    input  wire logic        a_clk,
    input  wire logic        reset_flg,
    input  wire logic        run,
    input  wire logic        pause,        // honoured at point steps only
    input  wire gvp_word_t   idle_options,
    input  wire gvp_word_t   cur_n,
    input  wire gvp_word_t   cur_nii,
    input  wire gvp_word_t   cur_options,
    input  wire gvp_word_t   cur_deci,
    input  wire gvp_word_t   loop_cnt,
    input  wire gvp_jump_t   cur_next,
    input  wire logic        store_ok,     // credit available
    output gvp_addr_t        pvc,
    output logic             step_en,
    output logic             loop_dec,
    output logic             loop_reload,
    output logic             store_req,
    output store_kind_t      store_kind,
    output gvp_word_t        options,
    output logic             finished,
    output logic             held,
    output gvp_word_t        point_index,  // points left in section
    output gvp_word_t        section_count
);

    seq_state_t state;
    gvp_word_t  ii_cnt;      // silent steps left before the point
    gvp_word_t  deci_cnt;    // cycles to the next step
    gvp_word_t  run_options; // option word of the running vector

    logic tick;
    logic at_point;
    logic in_step;
    logic pt_take;
    logic sec_end;
    logic signed [`GVP_ADDR_W+1:0] jump_tgt; // room for under/overflow

    ////////////////////////////////////////////////////////////
    // step decode
    ////////////////////////////////////////////////////////////

    always_comb
    begin
        in_step  = (state == SEQ_STEP);
        tick     = (deci_cnt == '0);
        at_point = (ii_cnt == '0);
        held     = in_step && tick && at_point && pause; // parked at the point
        pt_take  = in_step && tick && at_point && !pause && store_ok;
        step_en  = (in_step && tick && !at_point) || pt_take;
        sec_end  = pt_take && (point_index == '0);
        loop_dec    = sec_end && (loop_cnt != '0);
        loop_reload = sec_end && (loop_cnt == '0);
        // header in LOAD, point sample at an unpaused point step
        store_req  = (state == SEQ_LOAD) || (in_step && tick && at_point && !pause);
        store_kind = (state == SEQ_LOAD) ? STORE_HEADER : STORE_POINT;
        jump_tgt   = $signed({2'b00, pvc}) + cur_next;
    end

    // idle and done hand out the host's idle options
    assign options = (state == SEQ_LOAD || state == SEQ_STEP) ? run_options : idle_options;

    ////////////////////////////////////////////////////////////
    // state and counters
    ////////////////////////////////////////////////////////////

    always_ff @(posedge a_clk)
    begin
        if (reset_flg)
        begin
            state         <= SEQ_IDLE;
            pvc           <= '0;
            point_index   <= '0;
            ii_cnt        <= '0;
            deci_cnt      <= '0;
            run_options   <= idle_options;
            finished      <= 1'b0;
            section_count <= '0;
        end
        else if (!run)
        begin
            state       <= SEQ_IDLE; // abort from anywhere
            finished    <= 1'b0;
            run_options <= idle_options;
        end
        else
        begin
            case (state)
                SEQ_IDLE:
                begin
                    state         <= SEQ_LOAD; // program starts at slot 0
                    pvc           <= '0;
                    section_count <= '0;
                end
                SEQ_LOAD:
                begin
                    if (store_ok) // header needs a credit too
                    begin
                        point_index <= cur_n;
                        ii_cnt      <= cur_nii;
                        deci_cnt    <= cur_deci;
                        if (cur_n == '0)
                        begin
                            state    <= SEQ_DONE; // end vector
                            finished <= 1'b1;
                        end
                        else
                        begin
                            state       <= SEQ_STEP;
                            run_options <= cur_options;
                        end
                    end
                end
                SEQ_STEP:
                begin
                    if (!tick)
                        deci_cnt <= deci_cnt - 1'b1;
                    else if (!at_point)
                    begin
                        ii_cnt   <= ii_cnt - 1'b1; // silent step
                        deci_cnt <= cur_deci;
                    end
                    else if (pt_take)
                    begin
                        deci_cnt <= cur_deci;
                        if (point_index != '0)
                        begin
                            point_index <= point_index - 1'b1;
                            ii_cnt      <= cur_nii;
                        end
                        else
                        begin
                            // section complete, loop back or fall through
                            section_count <= section_count + 1'b1;
                            state         <= SEQ_LOAD;
                            if (loop_cnt != '0)
                                pvc <= jump_tgt[`GVP_ADDR_W-1:0];
                            else
                                pvc <= pvc + 1'b1;
                        end
                    end
                end
                SEQ_DONE:
                begin
                    state <= SEQ_DONE; // hold until run drops
                end
                default:
                begin
                    state <= SEQ_IDLE;
                end
            endcase
        end
    end

    // a taken loop must land on a real table slot
    a_jump_in_range: assert property (@(posedge a_clk) disable iff (reset_flg)
        loop_dec |-> (jump_tgt >= 0) && (jump_tgt < `GVP_NUM_VECTORS));

endmodule

`default_nettype wire

// ==== vector_accumulator.sv ====
`default_nettype none

module vector_accumulator
    import gvp_pkg::*;
(
    input  wire logic       a_clk,
    input  wire logic       reset_flg,
    input  wire logic       step_en, // one step of the current vector
    input  wire gvp_coord_t cur_dx,
    input  wire gvp_coord_t cur_dy,
    input  wire gvp_coord_t cur_dz,
    input  wire gvp_coord_t cur_du,
    output gvp_coord_t      pos_x,
    output gvp_coord_t      pos_y,
    output gvp_coord_t      pos_z,
    output gvp_coord_t      pos_u
);

    ////////////////////////////////////////////////////////////
    // position integrators
    ////////////////////////////////////////////////////////////

    // plain adds, overflow wraps around in two's complement
    always_ff @(posedge a_clk)
    begin
        if (reset_flg)
        begin
            pos_x <= '0; // origin
            pos_y <= '0;
            pos_z <= '0;
            pos_u <= '0;
        end
        else if (step_en)
        begin
            pos_x <= pos_x + cur_dx;
            pos_y <= pos_y + cur_dy;
            pos_z <= pos_z + cur_dz;
            pos_u <= pos_u + cur_du; // aux axis, same rule
        end
    end

endmodule

`default_nettype wire

// ==== store_credit_ctrl.sv ====
`default_nettype none

`include "gvp_params.svh"

module store_credit_ctrl
    import gvp_pkg::*;
(
    input  wire logic        a_clk,
    input  wire logic        reset_flg,
    input  wire logic        store_req,     // sequencer wants a store
    input  wire store_kind_t store_kind_in,
    input  wire logic        store_credit,  // one credit back from recorder
    output logic             store_ok,
    output logic             store_valid,
    output store_kind_t      store_kind
);

    localparam int CRED_W = $clog2(`GVP_STORE_CREDITS + 1);

    logic [CRED_W-1:0] credits; // free recorder slots
    logic              take;

    assign store_ok = (credits != '0);
    assign take     = store_req && store_ok;

    always_ff @(posedge a_clk)
    begin
        if (reset_flg)
            credits <= CRED_W'(`GVP_STORE_CREDITS); // recorder empty
        else if (take && !store_credit)
            credits <= credits - 1'b1;
        else if (!take && store_credit)
            credits <= credits + 1'b1;
        // take plus return leaves the count alone
    end

    // registered event toward the recorder
    always_ff @(posedge a_clk)
    begin
        if (reset_flg)
            store_valid <= 1'b0;
        else
            store_valid <= take;
    end

    always_ff @(posedge a_clk)
    begin
        if (take)
            store_kind <= store_kind_in; // held until the next event
    end

    // recorder returns no more than it was given
    a_credit_no_overflow: assert property (@(posedge a_clk) disable iff (reset_flg)
        (store_credit && !take) |-> (credits < CRED_W'(`GVP_STORE_CREDITS)));

    // an underflow wraps above the depth, so one bound covers both ends
    a_credit_bounded: assert property (@(posedge a_clk) disable iff (reset_flg)
        credits <= CRED_W'(`GVP_STORE_CREDITS));

endmodule

`default_nettype wire

// ==== gvp_core.sv ====
`default_nettype none

module gvp_core
    import gvp_pkg::*;
(
    input  wire logic       a_clk,
    input  wire logic       reset_flg,
    input  wire logic       setvec,
    input  wire gvp_addr_t  vec_addr,
    input  wire gvp_word_t  set_n,
    input  wire gvp_word_t  set_nii,
    input  wire gvp_word_t  set_options,
    input  wire gvp_word_t  set_nrep,
    input  wire gvp_word_t  set_deci,
    input  wire gvp_jump_t  set_next,
    input  wire gvp_coord_t set_dx,
    input  wire gvp_coord_t set_dy,
    input  wire gvp_coord_t set_dz,
    input  wire gvp_coord_t set_du,
    input  wire logic       run,
    input  wire logic       pause,
    input  wire gvp_word_t  idle_options,
    input  wire logic       store_credit,  // from the data recorder
    output gvp_coord_t      pos_x,
    output gvp_coord_t      pos_y,
    output gvp_coord_t      pos_z,
    output gvp_coord_t      pos_u,
    output gvp_word_t       options,
    output logic            store_valid,
    output store_kind_t     store_kind,
    output logic            finished,
    output logic            held,
    output gvp_word_t       point_index,
    output gvp_word_t       section_count
);

    ////////////////////////////////////////////////////////////
    // internal nets
    ////////////////////////////////////////////////////////////

    gvp_addr_t   pvc;
    gvp_word_t   cur_n, cur_nii, cur_options, cur_deci, loop_cnt;
    gvp_jump_t   cur_next;
    gvp_coord_t  cur_dx, cur_dy, cur_dz, cur_du;
    logic        step_en, loop_dec, loop_reload;
    logic        store_req, store_ok;
    store_kind_t seq_kind; // kind requested, before the register

    vector_program_ram i_ram (
        .a_clk(a_clk), .reset_flg(reset_flg), .setvec(setvec), .vec_addr(vec_addr),
        .set_n(set_n), .set_nii(set_nii), .set_options(set_options),
        .set_nrep(set_nrep), .set_deci(set_deci), .set_next(set_next),
        .set_dx(set_dx), .set_dy(set_dy), .set_dz(set_dz), .set_du(set_du),
        .run(run), .pvc(pvc), .loop_dec(loop_dec), .loop_reload(loop_reload),
        .cur_n(cur_n), .cur_nii(cur_nii), .cur_options(cur_options),
        .cur_deci(cur_deci), .loop_cnt(loop_cnt), .cur_next(cur_next),
        .cur_dx(cur_dx), .cur_dy(cur_dy), .cur_dz(cur_dz), .cur_du(cur_du)
    );

    step_sequencer i_seq (
        .a_clk(a_clk), .reset_flg(reset_flg), .run(run), .pause(pause),
        .idle_options(idle_options), .cur_n(cur_n), .cur_nii(cur_nii),
        .cur_options(cur_options), .cur_deci(cur_deci), .loop_cnt(loop_cnt),
        .cur_next(cur_next), .store_ok(store_ok), .pvc(pvc), .step_en(step_en),
        .loop_dec(loop_dec), .loop_reload(loop_reload), .store_req(store_req),
        .store_kind(seq_kind), .options(options), .finished(finished), .held(held),
        .point_index(point_index), .section_count(section_count)
    );

    vector_accumulator i_acc (
        .a_clk(a_clk), .reset_flg(reset_flg), .step_en(step_en),
        .cur_dx(cur_dx), .cur_dy(cur_dy), .cur_dz(cur_dz), .cur_du(cur_du),
        .pos_x(pos_x), .pos_y(pos_y), .pos_z(pos_z), .pos_u(pos_u)
    );

    // credit gate between sequencer and recorder
    store_credit_ctrl i_cred (
        .a_clk(a_clk), .reset_flg(reset_flg), .store_req(store_req),
        .store_kind_in(seq_kind), .store_credit(store_credit), .store_ok(store_ok),
        .store_valid(store_valid), .store_kind(store_kind)
    );

endmodule

`default_nettype wire

// ==== tb_gvp_core.sv ====
`default_nettype none

`include "gvp_params.svh"

module tb_gvp_core
    import gvp_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int CLK_PERIOD = 8;
    localparam int CREDIT_LAT = 3;     // recorder turnaround, cycles
    localparam int BUDGET_RESET = 20;
    localparam int BUDGET_SINGLE = 120;
    localparam int BUDGET_LOOP = 300;
    localparam int BUDGET_BP = 200;
    localparam int BUDGET_PAUSE = 200;
    localparam int BUDGET_DECI = 300;
    localparam int BUDGET_TOTAL = BUDGET_RESET + BUDGET_SINGLE + BUDGET_LOOP
                                  + BUDGET_BP + BUDGET_PAUSE + BUDGET_DECI;
    localparam int WATCHDOG_NS = (BUDGET_TOTAL + 200) * CLK_PERIOD; // slack for resets
    localparam gvp_word_t IDLE_OPTS = 32'h0000_0F00;

    logic       a_clk;
    logic       reset_flg;
    logic       setvec;
    gvp_addr_t  vec_addr;
    gvp_word_t  set_n, set_nii, set_options, set_nrep, set_deci;
    gvp_jump_t  set_next;
    gvp_coord_t set_dx, set_dy, set_dz, set_du;
    logic       run;
    logic       pause;
    gvp_word_t  idle_options;
    logic       store_credit;

    gvp_coord_t  pos_x, pos_y, pos_z, pos_u;
    gvp_word_t   options;
    logic        store_valid;
    store_kind_t store_kind;
    logic        finished;
    logic        held;
    gvp_word_t   point_index;
    gvp_word_t   section_count;

    // recorder model state
    int   hdr_cnt;
    int   pt_cnt;
    int   owed;          // credits due but not yet handed back
    int   in_flight;
    int   max_in_flight;
    logic withhold;      // test stalls the credit return
    int   due_q[$];      // return times, recorder cycles
    int   rec_cyc;

    int   err_cnt;
    int   chk_cnt;
    int   tests_run;

    gvp_core i_dut (
        .a_clk(a_clk), .reset_flg(reset_flg), .setvec(setvec), .vec_addr(vec_addr),
        .set_n(set_n), .set_nii(set_nii), .set_options(set_options),
        .set_nrep(set_nrep), .set_deci(set_deci), .set_next(set_next),
        .set_dx(set_dx), .set_dy(set_dy), .set_dz(set_dz), .set_du(set_du),
        .run(run), .pause(pause), .idle_options(idle_options),
        .store_credit(store_credit), .pos_x(pos_x), .pos_y(pos_y), .pos_z(pos_z),
        .pos_u(pos_u), .options(options), .store_valid(store_valid),
        .store_kind(store_kind), .finished(finished), .held(held),
        .point_index(point_index), .section_count(section_count)
    );

    always #(CLK_PERIOD / 2) a_clk = ~a_clk;

    ////////////////////////////////////////////////////////////
    // data recorder, counts events and returns credits
    ////////////////////////////////////////////////////////////

    always @(posedge a_clk)
    begin
        #1; // outputs settled after the edge
        rec_cyc = rec_cyc + 1;
        if (reset_flg)
        begin
            due_q.delete(); // buffer flushed
            owed = 0;
            in_flight = 0;
            store_credit = 1'b0;
        end
        else
        begin
            if (store_valid)
            begin
                if (store_kind == STORE_HEADER)
                    hdr_cnt = hdr_cnt + 1;
                else
                    pt_cnt = pt_cnt + 1;
                due_q.push_back(rec_cyc + CREDIT_LAT);
                in_flight = in_flight + 1;
                if (in_flight > max_in_flight)
                    max_in_flight = in_flight;
            end
            while (due_q.size() > 0 && due_q[0] <= rec_cyc)
            begin
                owed = owed + 1;
                void'(due_q.pop_front());
            end
            if (!withhold && owed > 0)
            begin
                store_credit = 1'b1; // one credit per cycle
                owed = owed - 1;
                in_flight = in_flight - 1;
            end
            else
                store_credit = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////

    task automatic wait_cycles(input int n);
        for (int i = 0; i < n; i++)
        begin
            @(posedge a_clk);
            #1;
        end
    endtask

    task automatic apply_reset();
        reset_flg = 1'b1;
        run = 1'b0;
        pause = 1'b0;
        setvec = 1'b0;
        wait_cycles(3);
        reset_flg = 1'b0;
    endtask

    task automatic write_vector(input gvp_addr_t a, input gvp_word_t n, input gvp_word_t nii,
                                input gvp_word_t opts, input gvp_word_t nrep,
                                input gvp_word_t deci, input gvp_jump_t nxt,
                                input gvp_coord_t dx, input gvp_coord_t dy,
                                input gvp_coord_t dz, input gvp_coord_t du);
        vec_addr = a;
        set_n = n;
        set_nii = nii;
        set_options = opts;
        set_nrep = nrep;
        set_deci = deci;
        set_next = nxt;
        set_dx = dx;
        set_dy = dy;
        set_dz = dz;
        set_du = du;
        setvec = 1'b1;
        wait_cycles(1);
        setvec = 1'b0;
    endtask

    task automatic clear_counts();
        hdr_cnt = 0;
        pt_cnt = 0;
        max_in_flight = 0;
    endtask

    task automatic wait_finished(input int budget, input string tname);
        int i;
        i = 0;
        while (!finished && i < budget)
        begin
            wait_cycles(1);
            i++;
        end
        if (!finished)
        begin
            $display("ERROR at %0t ns: %s never raised finished within %0d cycles",
                     $time, tname, budget);
            err_cnt++;
        end
    endtask

    // expected travel of one axis: steps per section times passes times increment
    function automatic gvp_coord_t travel(input int n, input int nii, input int passes,
                                          input gvp_coord_t d);
        return gvp_coord_t'((n + 1) * (nii + 1) * passes) * d;
    endfunction

    task automatic check_coord(input string what, input gvp_coord_t got,
                               input gvp_coord_t exp);
        chk_cnt++;
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t ns: %s got %0d expected %0d", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_word(input string what, input gvp_word_t got, input gvp_word_t exp);
        chk_cnt++;
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t ns: %s got 0x%0h expected 0x%0h",
                     $time, what, got, exp);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input string what, input logic got, input logic exp);
        chk_cnt++;
        if (got !== exp)
        begin
            $display("CHECK FAILED at %0t ns: %s got %b expected %b", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    // end-of-program state, counts settle two cycles after finished
    task automatic check_result(input gvp_coord_t ex, input gvp_coord_t ey,
                                input gvp_coord_t ez, input gvp_coord_t eu,
                                input int pts, input int hdrs, input int secs);
        wait_cycles(2);
        check_flag("finished", finished, 1'b1);
        check_coord("pos_x", pos_x, ex);
        check_coord("pos_y", pos_y, ey);
        check_coord("pos_z", pos_z, ez);
        check_coord("pos_u", pos_u, eu);
        check_word("point stores", pt_cnt, pts);
        check_word("header stores", hdr_cnt, hdrs);
        check_word("section_count", section_count, secs);
        check_word("options when done", options, IDLE_OPTS);
    endtask

    task automatic end_test(input string name, input int errs_before);
        tests_run++;
        $display("test %s finished, %0d errors", name, err_cnt - errs_before);
    endtask

    // 4 points of 3 steps each, then the end vector
    task automatic load_single_program();
        write_vector(4'd0, 3, 2, 32'h11, 0, 0, 0, 7, -5, 100, -1);
        write_vector(4'd1, 0, 0, 32'h0, 0, 0, 0, 0, 0, 0, 0);
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    task automatic test_reset_state();
        int e0;
        e0 = err_cnt;
        apply_reset();
        check_coord("pos_x after reset", pos_x, 0);
        check_coord("pos_y after reset", pos_y, 0);
        check_coord("pos_z after reset", pos_z, 0);
        check_coord("pos_u after reset", pos_u, 0);
        check_flag("finished after reset", finished, 1'b0);
        check_flag("store_valid after reset", store_valid, 1'b0);
        check_word("options after reset", options, IDLE_OPTS);
        end_test("reset_state", e0);
    endtask

    task automatic test_single_vector();
        int e0;
        e0 = err_cnt;
        apply_reset();
        load_single_program();
        clear_counts();
        run = 1'b1;
        wait_finished(BUDGET_SINGLE, "single_vector");
        check_result(travel(3, 2, 1, 7), travel(3, 2, 1, -5), travel(3, 2, 1, 100),
                     travel(3, 2, 1, -1), 4, 2, 1);
        run = 1'b0;
        end_test("single_vector", e0);
    endtask

    task automatic test_loop();
        int e0;
        gvp_coord_t ex, ey, ez, eu;
        e0 = err_cnt;
        apply_reset();
        write_vector(4'd0, 1, 1, 32'h21, 0, 0, 0, 3, -2, 1, 5);
        write_vector(4'd1, 2, 0, 32'h22, 2, 0, -1, -1, 4, 0, 2); // back to slot 0, twice
        write_vector(4'd2, 0, 0, 32'h0, 0, 0, 0, 0, 0, 0, 0);
        ex = travel(1, 1, 3, 3) + travel(2, 0, 3, -1);
        ey = travel(1, 1, 3, -2) + travel(2, 0, 3, 4);
        ez = travel(1, 1, 3, 1) + travel(2, 0, 3, 0);
        eu = travel(1, 1, 3, 5) + travel(2, 0, 3, 2);
        clear_counts();
        run = 1'b1;
        wait_finished(BUDGET_LOOP / 2, "loop first run");
        check_result(ex, ey, ez, eu, 15, 7, 6);
        run = 1'b0;
        wait_cycles(2);
        check_flag("finished after run drop", finished, 1'b0);
        // same program again, positions keep adding
        clear_counts();
        run = 1'b1;
        wait_finished(BUDGET_LOOP / 2, "loop second run");
        check_result(2 * ex, 2 * ey, 2 * ez, 2 * eu, 15, 7, 6);
        run = 1'b0;
        end_test("loop", e0);
    endtask

    task automatic test_back_pressure();
        int e0;
        e0 = err_cnt;
        apply_reset();
        load_single_program();
        clear_counts();
        withhold = 1'b1; // recorder keeps its credits
        run = 1'b1;
        wait_cycles(40);
        check_flag("stores within credit depth",
                   (hdr_cnt + pt_cnt) <= `GVP_STORE_CREDITS, 1'b1);
        check_flag("finished while stalled", finished, 1'b0);
        withhold = 1'b0;
        wait_finished(BUDGET_BP - 40, "back_pressure");
        check_result(travel(3, 2, 1, 7), travel(3, 2, 1, -5), travel(3, 2, 1, 100),
                     travel(3, 2, 1, -1), 4, 2, 1);
        check_flag("in-flight within credit depth",
                   max_in_flight <= `GVP_STORE_CREDITS, 1'b1);
        run = 1'b0;
        end_test("back_pressure", e0);
    endtask

    task automatic test_pause();
        int e0;
        int i;
        int paused_pts;
        e0 = err_cnt;
        paused_pts = 0;
        apply_reset();
        write_vector(4'd0, 3, 2, 32'h31, 0, 1, 0, 2, 3, -4, 1);
        write_vector(4'd1, 0, 0, 32'h0, 0, 0, 0, 0, 0, 0, 0);
        clear_counts();
        run = 1'b1;
        wait_cycles(5);
        pause = 1'b1;
        i = 0;
        while (!held && i < 50)
        begin
            wait_cycles(1);
            if (store_valid && store_kind == STORE_POINT)
                paused_pts++;
            i++;
        end
        check_flag("held raised", held, 1'b1);
        for (i = 0; i < 15; i++)
        begin
            wait_cycles(1);
            check_flag("held stays high", held, 1'b1);
            if (store_valid && store_kind == STORE_POINT)
                paused_pts++;
        end
        check_word("point stores while paused", paused_pts, 0);
        pause = 1'b0;
        wait_finished(BUDGET_PAUSE - 80, "pause");
        check_result(travel(3, 2, 1, 2), travel(3, 2, 1, 3), travel(3, 2, 1, -4),
                     travel(3, 2, 1, 1), 4, 2, 1);
        run = 1'b0;
        end_test("pause", e0);
    endtask

    task automatic test_decimation();
        int e0;
        int i;
        int last;
        int gap_min;
        int pts_seen;
        e0 = err_cnt;
        last = -1;
        pts_seen = 0;
        gap_min = (1 + 1) * (2 + 1); // (nii+1)(d+1)
        apply_reset();
        write_vector(4'd0, 3, 1, 32'h0000_00A5, 0, 2, 0, 1, -1, 9, 0);
        write_vector(4'd1, 0, 0, 32'h0, 0, 0, 0, 0, 0, 0, 0);
        clear_counts();
        run = 1'b1;
        for (i = 0; i < BUDGET_DECI && !finished; i++)
        begin
            wait_cycles(1);
            if (store_valid && store_kind == STORE_POINT)
            begin
                pts_seen++;
                if (last >= 0)
                    check_flag("point store spacing", (i - last) >= gap_min, 1'b1);
                check_word("options while running", options, 32'h0000_00A5);
                // counter starts at n and runs down to zero at the last point
                check_word("point_index at point store", point_index,
                           (pts_seen < 3) ? 3 - pts_seen : 0);
                last = i;
            end
        end
        if (!finished)
        begin
            $display("ERROR at %0t ns: decimation program never finished", $time);
            err_cnt++;
        end
        check_result(travel(3, 1, 1, 1), travel(3, 1, 1, -1), travel(3, 1, 1, 9),
                     0, 4, 2, 1);
        run = 1'b0;
        end_test("decimation", e0);
    endtask

    ////////////////////////////////////////////////////////////
    // main sequence and watchdog
    ////////////////////////////////////////////////////////////

    initial
    begin
        a_clk = 1'b0;
        reset_flg = 1'b1;
        setvec = 1'b0;
        vec_addr = '0;
        set_n = '0;
        set_nii = '0;
        set_options = '0;
        set_nrep = '0;
        set_deci = '0;
        set_next = '0;
        set_dx = '0;
        set_dy = '0;
        set_dz = '0;
        set_du = '0;
        run = 1'b0;
        pause = 1'b0;
        idle_options = IDLE_OPTS;
        store_credit = 1'b0;
        withhold = 1'b0;
        rec_cyc = 0;
        err_cnt = 0;
        chk_cnt = 0;
        tests_run = 0;
        clear_counts();

        test_reset_state();
        test_single_vector();
        test_loop();
        test_back_pressure();
        test_pause();
        test_decimation();

        $display("tests %0d, checks %0d, errors %0d", tests_run, chk_cnt, err_cnt);
        if (err_cnt == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired at %0t ns, the tests did not complete", $time);
        $display("Result: FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== gvp_core.f ====
+incdir+.
gvp_pkg.sv
vector_program_ram.sv
step_sequencer.sv
vector_accumulator.sv
store_credit_ctrl.sv
gvp_core.sv
tb_gvp_core.sv
